// ==== src/oooExec_consts.svh ====
`ifndef OOOEXEC_CONSTS_SVH
`define OOOEXEC_CONSTS_SVH

// ==============================
// Datapath widths
// ==============================

// Data and address width.
`define DATA_W 32

// ROB tag width.
`define NICK_W 4

// ==============================
// Reservation station sizing
// ==============================

// Number of entries, any value from 2 up.
`define RS_SIZE 4

// Must cover RS_SIZE entries.
`define RS_IDX_W 2

`endif

// ==== src/oooExecPkg.sv ====
package oooExecPkg;

    // Executed RV32I operations.
    typedef enum logic [4:0] {
        LUI,
        AUIPC,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        ADDI,
        SLTI,
        SLTIU,
        XORI,
        ORI,
        ANDI,
        SLLI,
        SRLI,
        SRAI,
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } opcode_e;

    typedef enum logic [1:0] {
        FREE,
        WAITING,   // At least one operand still pending.
        READY
    } entryState_e;

endpackage

// ==== src/issueReceiver.sv ====
`timescale 1ns/1ps

module issueReceiver (
    input  logic clk,
    input  logic rst,
    input  logic rdy,
    input  logic flush,
    input  logic issueReq,
    input  logic hasFree,
    output logic issueAck,
    output logic allocEn
);

    typedef enum logic {
        IDLE,
        ACKING
    } rxState_e;

    rxState_e state;

    // ==============================
    // Four-phase handshake
    // ==============================

    // Ack is high for the whole second half of the handshake.
    assign issueAck = (state == ACKING);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            allocEn <= 1'b0;
        end else if (rdy) begin
            allocEn <= 1'b0;
            case (state)
                IDLE: begin
                    // Full station or flush holds the request off.
                    if (issueReq && hasFree && !flush) begin
                        state   <= ACKING;
                        allocEn <= 1'b1;   // One write per request.
                    end
                end
                ACKING: begin
                    if (!issueReq) begin
                        state <= IDLE;   // Ack drops after req.
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== src/reservationStation.sv ====
`timescale 1ns/1ps
`include "oooExec_consts.svh"

module reservationStation (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 flush,
    input  logic                 allocEn,
    input  oooExecPkg::opcode_e  issueOp,
    input  logic [`DATA_W-1:0]   issuePc,
    input  logic [`DATA_W-1:0]   issueImm,
    input  logic [`NICK_W-1:0]   issueNick,
    input  logic [`DATA_W-1:0]   issueSrc1Val,
    input  logic                 issueSrc1Ready,
    input  logic [`NICK_W-1:0]   issueSrc1Nick,
    input  logic [`DATA_W-1:0]   issueSrc2Val,
    input  logic                 issueSrc2Ready,
    input  logic [`NICK_W-1:0]   issueSrc2Nick,
    input  logic                 cdbEn,
    input  logic [`NICK_W-1:0]   cdbNick,
    input  logic [`DATA_W-1:0]   cdbData,
    output logic                 hasFree,
    output logic                 dispEn,
    output oooExecPkg::opcode_e  dispOp,
    output logic [`DATA_W-1:0]   dispPc,
    output logic [`DATA_W-1:0]   dispImm,
    output logic [`NICK_W-1:0]   dispNick,
    output logic [`DATA_W-1:0]   dispSrc1,
    output logic [`DATA_W-1:0]   dispSrc2
);
    import oooExecPkg::*;

    entryState_e          entState [`RS_SIZE];
    opcode_e              entOp    [`RS_SIZE];
    logic [`DATA_W-1:0]   entPc    [`RS_SIZE];
    logic [`DATA_W-1:0]   entImm   [`RS_SIZE];
    logic [`NICK_W-1:0]   entNick  [`RS_SIZE];
    logic [`DATA_W-1:0]   entVal1  [`RS_SIZE];
    logic [`DATA_W-1:0]   entVal2  [`RS_SIZE];
    logic [`NICK_W-1:0]   entTag1  [`RS_SIZE];
    logic [`NICK_W-1:0]   entTag2  [`RS_SIZE];
    logic [`RS_SIZE-1:0]  entRdy1;
    logic [`RS_SIZE-1:0]  entRdy2;
    logic [`RS_SIZE-1:0]  hit1;
    logic [`RS_SIZE-1:0]  hit2;
    logic [`RS_IDX_W-1:0] allocIdx;
    logic [`RS_IDX_W-1:0] dispIdx;
    logic                 newRdy1;
    logic                 newRdy2;
    logic [`DATA_W-1:0]   newVal1;
    logic [`DATA_W-1:0]   newVal2;
    logic                 doAlloc;
    logic                 doDisp;

    // ==============================
    // CDB snoop and slot selection
    // ==============================

    always_comb begin
        for (int i = 0; i < `RS_SIZE; i++) begin
            hit1[i] = cdbEn && !entRdy1[i] && (entTag1[i] == cdbNick);
            hit2[i] = cdbEn && !entRdy2[i] && (entTag2[i] == cdbNick);
        end
    end

    // Walk downward so the lowest index wins.
    always_comb begin
        hasFree  = 1'b0;
        allocIdx = '0;
        dispEn   = 1'b0;
        dispIdx  = '0;
        for (int i = `RS_SIZE - 1; i >= 0; i--) begin
            if (entState[i] == FREE) begin
                hasFree  = 1'b1;
                allocIdx = `RS_IDX_W'(i);
            end
            if (entState[i] == READY) begin
                dispEn  = 1'b1;
                dispIdx = `RS_IDX_W'(i);
            end
        end
    end

    // Same-cycle broadcast counts as known.
    assign newRdy1 = issueSrc1Ready || (cdbEn && (issueSrc1Nick == cdbNick));
    assign newRdy2 = issueSrc2Ready || (cdbEn && (issueSrc2Nick == cdbNick));
    assign newVal1 = issueSrc1Ready ? issueSrc1Val : cdbData;
    assign newVal2 = issueSrc2Ready ? issueSrc2Val : cdbData;

    assign doAlloc = allocEn && hasFree && rdy && !flush;
    assign doDisp  = dispEn && rdy && !flush;

    assign dispOp   = entOp[dispIdx];
    assign dispPc   = entPc[dispIdx];
    assign dispImm  = entImm[dispIdx];
    assign dispNick = entNick[dispIdx];
    assign dispSrc1 = entVal1[dispIdx];
    assign dispSrc2 = entVal2[dispIdx];

    // ==============================
    // Entry state
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            entRdy1 <= '0;
            entRdy2 <= '0;
            for (int i = 0; i < `RS_SIZE; i++) begin
                entState[i] <= FREE;
            end
        end else if (rdy) begin
            if (flush) begin
                for (int i = 0; i < `RS_SIZE; i++) begin
                    entState[i] <= FREE;
                end
            end else begin
                for (int i = 0; i < `RS_SIZE; i++) begin
                    if (entState[i] == WAITING) begin
                        if (hit1[i]) entRdy1[i] <= 1'b1;
                        if (hit2[i]) entRdy2[i] <= 1'b1;
                        if ((entRdy1[i] || hit1[i]) && (entRdy2[i] || hit2[i])) begin
                            entState[i] <= READY;
                        end
                    end
                end
                if (doDisp) entState[dispIdx] <= FREE;   // Taken by execute.
                if (doAlloc) begin
                    entState[allocIdx] <= (newRdy1 && newRdy2) ? READY : WAITING;
                    entRdy1[allocIdx]  <= newRdy1;
                    entRdy2[allocIdx]  <= newRdy2;
                end
            end
        end
    end

    // Payload.
    always_ff @(posedge clk) begin
        if (rdy) begin
            for (int i = 0; i < `RS_SIZE; i++) begin
                if (entState[i] == WAITING) begin
                    if (hit1[i]) entVal1[i] <= cdbData;
                    if (hit2[i]) entVal2[i] <= cdbData;
                end
            end
            if (doAlloc) begin
                entOp[allocIdx]   <= issueOp;
                entPc[allocIdx]   <= issuePc;
                entImm[allocIdx]  <= issueImm;
                entNick[allocIdx] <= issueNick;
                entVal1[allocIdx] <= newVal1;
                entVal2[allocIdx] <= newVal2;
                entTag1[allocIdx] <= issueSrc1Nick;
                entTag2[allocIdx] <= issueSrc2Nick;
            end
        end
    end

endmodule

// ==== src/execute.sv ====
`timescale 1ns/1ps
`include "oooExec_consts.svh"

module execute (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 flush,
    input  logic                 dispEn,
    input  oooExecPkg::opcode_e  dispOp,
    input  logic [`DATA_W-1:0]   dispPc,
    input  logic [`DATA_W-1:0]   dispImm,
    input  logic [`NICK_W-1:0]   dispNick,
    input  logic [`DATA_W-1:0]   dispSrc1,
    input  logic [`DATA_W-1:0]   dispSrc2,
    output logic                 cdbEn,
    output logic [`NICK_W-1:0]   cdbNick,
    output logic [`DATA_W-1:0]   cdbData,
    output logic                 cdbJump,
    output logic [`DATA_W-1:0]   cdbJumpPc
);
    import oooExecPkg::*;

    logic [`DATA_W-1:0] aluData;
    logic               taken;
    logic [`DATA_W-1:0] target;
    logic [`DATA_W-1:0] jumpPc;
    logic [`DATA_W-1:0] pcPlusImm;
    logic [`DATA_W-1:0] pcPlus4;
    logic [4:0]         shImm;
    logic [4:0]         shReg;

    assign pcPlusImm = dispPc + dispImm;
    assign pcPlus4   = dispPc + `DATA_W'(4);
    assign shImm     = dispImm[4:0];
    assign shReg     = dispSrc2[4:0];

    // ==============================
    // ALU and branch compare
    // ==============================

    always_comb begin
        aluData = '0;
        taken   = 1'b0;
        target  = pcPlusImm;
        case (dispOp)
            LUI:   aluData = dispImm;
            AUIPC: aluData = pcPlusImm;
            JAL: begin
                aluData = pcPlus4;
                taken   = 1'b1;
            end
            JALR: begin
                aluData = pcPlus4;
                taken   = 1'b1;
                target  = dispSrc1 + dispImm;   // Register-relative.
            end
            // Not-taken branches leave data at zero.
            BEQ:   taken = (dispSrc1 == dispSrc2);
            BNE:   taken = (dispSrc1 != dispSrc2);
            BLT:   taken = ($signed(dispSrc1) < $signed(dispSrc2));
            BGE:   taken = ($signed(dispSrc1) >= $signed(dispSrc2));
            BLTU:  taken = (dispSrc1 < dispSrc2);
            BGEU:  taken = (dispSrc1 >= dispSrc2);
            ADDI:  aluData = dispSrc1 + dispImm;
            SLTI:  aluData = `DATA_W'($signed(dispSrc1) < $signed(dispImm));
            SLTIU: aluData = `DATA_W'(dispSrc1 < dispImm);
            XORI:  aluData = dispSrc1 ^ dispImm;
            ORI:   aluData = dispSrc1 | dispImm;
            ANDI:  aluData = dispSrc1 & dispImm;
            SLLI:  aluData = dispSrc1 << shImm;
            SRLI:  aluData = dispSrc1 >> shImm;
            SRAI:  aluData = $signed(dispSrc1) >>> shImm;
            ADD:   aluData = dispSrc1 + dispSrc2;
            SUB:   aluData = dispSrc1 - dispSrc2;
            SLL:   aluData = dispSrc1 << shReg;
            SLT:   aluData = `DATA_W'($signed(dispSrc1) < $signed(dispSrc2));
            SLTU:  aluData = `DATA_W'(dispSrc1 < dispSrc2);
            XOR:   aluData = dispSrc1 ^ dispSrc2;
            SRL:   aluData = dispSrc1 >> shReg;
            SRA:   aluData = $signed(dispSrc1) >>> shReg;
            OR:    aluData = dispSrc1 | dispSrc2;
            AND:   aluData = dispSrc1 & dispSrc2;
            default: ;
        endcase
    end

    assign jumpPc = taken ? target : '0;

    // ==============================
    // CDB register
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            cdbEn <= 1'b0;
        end else if (rdy) begin
            cdbEn <= dispEn && !flush;   // Flush kills the in-flight result.
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && dispEn) begin
            cdbNick   <= dispNick;
            cdbData   <= aluData;
            cdbJump   <= taken;
            cdbJumpPc <= jumpPc;
        end
    end

endmodule

// ==== src/oooExecTop.sv ====
`timescale 1ns/1ps
`include "oooExec_consts.svh"

module oooExecTop (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 flush,
    input  oooExecPkg::opcode_e  issueOp,
    input  logic [`DATA_W-1:0]   issuePc,
    input  logic [`DATA_W-1:0]   issueImm,
    input  logic [`NICK_W-1:0]   issueNick,
    input  logic [`DATA_W-1:0]   issueSrc1Val,
    input  logic                 issueSrc1Ready,
    input  logic [`NICK_W-1:0]   issueSrc1Nick,
    input  logic [`DATA_W-1:0]   issueSrc2Val,
    input  logic                 issueSrc2Ready,
    input  logic [`NICK_W-1:0]   issueSrc2Nick,
    input  logic                 issueReq,
    output logic                 issueAck,
    output logic                 cdbEn,
    output logic [`NICK_W-1:0]   cdbNick,
    output logic [`DATA_W-1:0]   cdbData,
    output logic                 cdbJump,
    output logic [`DATA_W-1:0]   cdbJumpPc
);
    import oooExecPkg::*;

    logic               allocEn;
    logic               hasFree;
    logic               dispEn;
    opcode_e            dispOp;
    logic [`DATA_W-1:0] dispPc;
    logic [`DATA_W-1:0] dispImm;
    logic [`NICK_W-1:0] dispNick;
    logic [`DATA_W-1:0] dispSrc1;
    logic [`DATA_W-1:0] dispSrc2;

    issueReceiver rx_i (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .flush    (flush),
        .issueReq (issueReq),
        .hasFree  (hasFree),
        .issueAck (issueAck),
        .allocEn  (allocEn)
    );

    // CDB loops back here for operand wakeup.
    reservationStation rs_i (
        .clk            (clk),
        .rst            (rst),
        .rdy            (rdy),
        .flush          (flush),
        .allocEn        (allocEn),
        .issueOp        (issueOp),
        .issuePc        (issuePc),
        .issueImm       (issueImm),
        .issueNick      (issueNick),
        .issueSrc1Val   (issueSrc1Val),
        .issueSrc1Ready (issueSrc1Ready),
        .issueSrc1Nick  (issueSrc1Nick),
        .issueSrc2Val   (issueSrc2Val),
        .issueSrc2Ready (issueSrc2Ready),
        .issueSrc2Nick  (issueSrc2Nick),
        .cdbEn          (cdbEn),
        .cdbNick        (cdbNick),
        .cdbData        (cdbData),
        .hasFree        (hasFree),
        .dispEn         (dispEn),
        .dispOp         (dispOp),
        .dispPc         (dispPc),
        .dispImm        (dispImm),
        .dispNick       (dispNick),
        .dispSrc1       (dispSrc1),
        .dispSrc2       (dispSrc2)
    );

    execute ex_i (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .flush     (flush),
        .dispEn    (dispEn),
        .dispOp    (dispOp),
        .dispPc    (dispPc),
        .dispImm   (dispImm),
        .dispNick  (dispNick),
        .dispSrc1  (dispSrc1),
        .dispSrc2  (dispSrc2),
        .cdbEn     (cdbEn),
        .cdbNick   (cdbNick),
        .cdbData   (cdbData),
        .cdbJump   (cdbJump),
        .cdbJumpPc (cdbJumpPc)
    );

endmodule

// ==== tb/oooExecTb.sv ====
`timescale 1ns/1ps
`include "oooExec_consts.svh"

module oooExecTb;
    import oooExecPkg::*;

    localparam int MAX_ROWS = 48;

    logic clk;
    logic rst;
    logic rdy;
    logic flush;
    opcode_e issueOp;
    logic [`DATA_W-1:0] issuePc;
    logic [`DATA_W-1:0] issueImm;
    logic [`NICK_W-1:0] issueNick;
    logic [`DATA_W-1:0] issueSrc1Val;
    logic issueSrc1Ready;
    logic [`NICK_W-1:0] issueSrc1Nick;
    logic [`DATA_W-1:0] issueSrc2Val;
    logic issueSrc2Ready;
    logic [`NICK_W-1:0] issueSrc2Nick;
    logic issueReq;
    logic issueAck;
    logic cdbEn;
    logic [`NICK_W-1:0] cdbNick;
    logic [`DATA_W-1:0] cdbData;
    logic cdbJump;
    logic [`DATA_W-1:0] cdbJumpPc;

    // Stimulus table.
    string rowName [MAX_ROWS];
    opcode_e rowOp [MAX_ROWS];
    logic [`DATA_W-1:0] rowPc [MAX_ROWS];
    logic [`DATA_W-1:0] rowImm [MAX_ROWS];
    logic [`DATA_W-1:0] rowV1 [MAX_ROWS];
    logic [`DATA_W-1:0] rowV2 [MAX_ROWS];
    logic rowR1 [MAX_ROWS];
    logic rowR2 [MAX_ROWS];
    logic [`NICK_W-1:0] rowT1 [MAX_ROWS];
    logic [`NICK_W-1:0] rowT2 [MAX_ROWS];
    logic [`NICK_W-1:0] rowNick [MAX_ROWS];
    int rowDep [MAX_ROWS];
    logic [`DATA_W-1:0] rowExpData [MAX_ROWS];
    logic rowExpJump [MAX_ROWS];
    logic [`DATA_W-1:0] rowExpPc [MAX_ROWS];
    int numRows = 0;

    // Scoreboard, indexed by nick.
    bit seen [16];
    bit forbidden [16];
    logic [`DATA_W-1:0] gotData [16];
    logic gotJump [16];
    logic [`DATA_W-1:0] gotPc [16];
    int gotSeq [16];
    int seqCount = 0;
    int errors = 0;
    int seed = 77;

    oooExecTop dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ==============================
    // Table construction
    // ==============================

    task automatic addRow(input string name, input opcode_e op, input logic [31:0] pc,
                          input logic [31:0] imm, input logic [31:0] v1, input logic [31:0] v2,
                          input logic [31:0] expData, input logic expJump,
                          input logic [31:0] expPc);
        rowName[numRows] = name;
        rowOp[numRows] = op;
        rowPc[numRows] = pc;
        rowImm[numRows] = imm;
        rowV1[numRows] = v1;
        rowV2[numRows] = v2;
        rowR1[numRows] = 1'b1;
        rowR2[numRows] = 1'b1;
        rowT1[numRows] = '0;
        rowT2[numRows] = '0;
        rowNick[numRows] = `NICK_W'(numRows % 12);   // Nicks 12 to 15 kept for flush.
        rowDep[numRows] = -1;
        rowExpData[numRows] = expData;
        rowExpJump[numRows] = expJump;
        rowExpPc[numRows] = expPc;
        numRows++;
    endtask

    // Source src of row waits on the result of row prod.
    task automatic waitOn(input int row, input int src, input int prod);
        if (src == 1) begin
            rowR1[row] = 1'b0;
            rowT1[row] = rowNick[prod];
            rowV1[row] = 32'hDEADBEEF;
        end else begin
            rowR2[row] = 1'b0;
            rowT2[row] = rowNick[prod];
            rowV2[row] = 32'hDEADBEEF;
        end
        rowDep[row] = prod;
    endtask

    task automatic fillTable();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] p;
        addRow("lui", LUI, 32'h1000, 32'h12345000, 0, 0, 32'h12345000, 0, 0);
        addRow("auipc", AUIPC, 32'h1000, 32'h2000, 0, 0, 32'h3000, 0, 0);
        addRow("addi", ADDI, 32'h1000, 32'hFFFFFFF1, 32'hF000000F, 0, 32'hF0000000, 0, 0);
        addRow("slti", SLTI, 32'h1000, 32'h1, 32'hF000000F, 0, 32'h1, 0, 0);
        addRow("sltiu", SLTIU, 32'h1000, 32'h1, 32'hF000000F, 0, 32'h0, 0, 0);
        addRow("xori", XORI, 32'h1000, 32'hFF, 32'hF000000F, 0, 32'hF00000F0, 0, 0);
        addRow("ori", ORI, 32'h1000, 32'hF00, 32'hF000000F, 0, 32'hF0000F0F, 0, 0);
        addRow("andi", ANDI, 32'h1000, 32'hFFFFFF00, 32'hF000000F, 0, 32'hF0000000, 0, 0);
        addRow("slli", SLLI, 32'h1000, 32'h4, 32'hF000000F, 0, 32'h000000F0, 0, 0);
        addRow("srli", SRLI, 32'h1000, 32'h4, 32'hF000000F, 0, 32'h0F000000, 0, 0);
        addRow("srai", SRAI, 32'h1000, 32'h4, 32'hF000000F, 0, 32'hFF000000, 0, 0);
        addRow("add", ADD, 32'h1000, 0, 32'hF000000F, 32'h24, 32'hF0000033, 0, 0);
        addRow("sub", SUB, 32'h1000, 0, 32'hF000000F, 32'h24, 32'hEFFFFFEB, 0, 0);
        addRow("sll", SLL, 32'h1000, 0, 32'hF000000F, 32'h24, 32'h000000F0, 0, 0);
        addRow("slt", SLT, 32'h1000, 0, 32'hF000000F, 32'h24, 32'h1, 0, 0);
        addRow("sltu", SLTU, 32'h1000, 0, 32'hF000000F, 32'h24, 32'h0, 0, 0);
        addRow("xor", XOR, 32'h1000, 0, 32'hF000000F, 32'h24, 32'hF000002B, 0, 0);
        addRow("srl", SRL, 32'h1000, 0, 32'hF000000F, 32'h24, 32'h0F000000, 0, 0);
        addRow("sra", SRA, 32'h1000, 0, 32'hF000000F, 32'h24, 32'hFF000000, 0, 0);
        addRow("or", OR, 32'h1000, 0, 32'hF000000F, 32'h24, 32'hF000002F, 0, 0);
        addRow("and", AND, 32'h1000, 0, 32'hF000000F, 32'h24, 32'h00000004, 0, 0);
        // Branches to 0x2040 when taken.
        addRow("beq taken", BEQ, 32'h2000, 32'h40, 32'h5, 32'h5, 0, 1, 32'h2040);
        addRow("beq not taken", BEQ, 32'h2000, 32'h40, 32'h5, 32'h6, 0, 0, 0);
        addRow("bne taken", BNE, 32'h2000, 32'h40, 32'h5, 32'h6, 0, 1, 32'h2040);
        addRow("blt signed", BLT, 32'h2000, 32'h40, 32'hFFFFFFFF, 32'h1, 0, 1, 32'h2040);
        addRow("bltu unsigned", BLTU, 32'h2000, 32'h40, 32'hFFFFFFFF, 32'h1, 0, 0, 0);
        addRow("bge signed", BGE, 32'h2000, 32'h40, 32'hFFFFFFFF, 32'h1, 0, 0, 0);
        addRow("bgeu unsigned", BGEU, 32'h2000, 32'h40, 32'hFFFFFFFF, 32'h1, 0, 1, 32'h2040);
        addRow("jal", JAL, 32'h2000, 32'h100, 0, 0, 32'h2004, 1, 32'h2100);
        addRow("jalr", JALR, 32'h2000, 32'h10, 32'h3000, 0, 32'h2004, 1, 32'h3010);
        // Chain issued consumer first, rows 30 to 32.
        a = $random(seed);
        b = $random(seed);
        c = $random(seed);
        addRow("chain sub", SUB, 0, 0, 0, 0, 0, 0, 0);
        addRow("chain xor", XOR, 0, 0, 0, c, 0, 0, 0);
        addRow("chain add", ADD, 0, 0, a, b, a + b, 0, 0);
        waitOn(31, 1, 32);
        waitOn(30, 2, 32);
        waitOn(30, 1, 31);
        rowExpData[31] = (a + b) ^ c;
        rowExpData[30] = rowExpData[31] - (a + b);
        // Fillers waiting on the later producer, rows 33 to 36.
        for (int k = 0; k < 4; k++) begin
            addRow("filler", ADDI, 0, k, 0, 0, 0, 0, 0);
            rowR1[numRows-1] = 1'b0;
            rowNick[numRows-1] = `NICK_W'(12 + k);
        end
        a = $random(seed);
        b = $random(seed);
        p = a + b;
        addRow("after flush", ADDI, 0, 32'h23, 32'h100, 0, 32'h123, 0, 0);
        addRow("wake addi", ADDI, 0, 32'h1, 0, 0, p + 1, 0, 0);
        addRow("wake xori", XORI, 0, 32'hFFFFFFFF, 0, 0, ~p, 0, 0);
        addRow("wake slli", SLLI, 0, 32'h1, 0, 0, p << 1, 0, 0);
        addRow("producer", ADD, 0, 0, a, b, p, 0, 0);
        for (int r = 38; r < 41; r++) waitOn(r, 1, 41);
        for (int r = 33; r < 37; r++) rowT1[r] = rowNick[41];
        addRow("stall ori", ORI, 0, 32'h5, 32'hA0, 0, 32'hA5, 0, 0);
        addRow("sra mask", SRA, 0, 0, 32'h80000000, 32'h3F, 32'hFFFFFFFF, 0, 0);
    endtask

    // ==============================
    // Checks and CDB monitor
    // ==============================

    task automatic checkValue(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        if (expVal !== actVal) begin
            $display("FAIL %s: expected %h, actual %h", name, expVal, actVal);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst && rdy && cdbEn) begin
            if (forbidden[cdbNick]) begin
                $display("ERROR: flushed nick %0d appeared on the CDB", cdbNick);
                errors++;
            end
            if (seen[cdbNick]) begin
                $display("ERROR: nick %0d was broadcast twice", cdbNick);
                errors++;
            end
            seen[cdbNick] = 1'b1;
            gotData[cdbNick] = cdbData;
            gotJump[cdbNick] = cdbJump;
            gotPc[cdbNick] = cdbJumpPc;
            gotSeq[cdbNick] = seqCount;
            seqCount++;
        end
    end

    function automatic bit allSeen(input int lo, input int hi);
        for (int r = lo; r < hi; r++) begin
            if (!seen[rowNick[r]]) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic waitAndCheck(input int lo, input int hi);
        int n;
        while (!allSeen(lo, hi)) @(negedge clk);
        for (int r = lo; r < hi; r++) begin
            n = rowNick[r];
            checkValue({rowName[r], " data"}, rowExpData[r], gotData[n]);
            checkValue({rowName[r], " jump"}, rowExpJump[r], gotJump[n]);
            checkValue({rowName[r], " jump pc"}, rowExpPc[r], gotPc[n]);
            if (rowDep[r] >= 0) begin
                checkValue({rowName[r], " order"}, 1, gotSeq[n] > gotSeq[rowNick[rowDep[r]]]);
            end
        end
        for (int r = lo; r < hi; r++) seen[rowNick[r]] = 1'b0;
    endtask

    // ==============================
    // Issue handshake
    // ==============================

    task automatic driveRow(input int r);
        issueOp = rowOp[r];
        issuePc = rowPc[r];
        issueImm = rowImm[r];
        issueNick = rowNick[r];
        issueSrc1Val = rowV1[r];
        issueSrc1Ready = rowR1[r];
        issueSrc1Nick = rowT1[r];
        issueSrc2Val = rowV2[r];
        issueSrc2Ready = rowR2[r];
        issueSrc2Nick = rowT2[r];
        issueReq = 1'b1;
    endtask

    task automatic finishHandshake();
        do @(negedge clk); while (!issueAck);
        issueReq = 1'b0;
        do @(negedge clk); while (issueAck);
    endtask

    task automatic issueRow(input int r);
        @(negedge clk);
        driveRow(r);
        finishHandshake();
    endtask

    task automatic runChunk(input int lo, input int hi);
        for (int r = lo; r < hi; r++) issueRow(r);
        waitAndCheck(lo, hi);
    endtask

    initial begin
        wait (numRows > 0);
        repeat (numRows * 20 + 200) @(posedge clk);
        $display("ERROR: timeout, results did not arrive within %0d cycles", numRows * 20 + 200);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        rdy = 1'b1;
        flush = 1'b0;
        issueReq = 1'b0;
        issueOp = LUI;
        issuePc = '0;
        issueImm = '0;
        issueNick = '0;
        issueSrc1Val = '0;
        issueSrc1Ready = 1'b0;
        issueSrc1Nick = '0;
        issueSrc2Val = '0;
        issueSrc2Ready = 1'b0;
        issueSrc2Nick = '0;
        fillTable();
        repeat (3) @(negedge clk);
        rst = 1'b0;

        runChunk(0, 12);
        runChunk(12, 21);
        runChunk(21, 30);
        runChunk(30, 33);

        // Station full, next request must stall.
        for (int r = 33; r < 37; r++) issueRow(r);
        @(negedge clk);
        driveRow(37);
        repeat (10) begin
            @(negedge clk);
            checkValue("backpressure ack", 0, issueAck);
        end
        issueReq = 1'b0;
        @(negedge clk);
        flush = 1'b1;
        for (int r = 33; r < 37; r++) forbidden[rowNick[r]] = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        runChunk(37, 42);

        // Global stall with a ready entry and a request pending.
        issueRow(43);
        rdy = 1'b0;
        driveRow(42);
        repeat (6) begin
            @(negedge clk);
            checkValue("stall ack", 0, issueAck);
            checkValue("stall cdbEn", 0, cdbEn);
        end
        rdy = 1'b1;
        finishHandshake();
        waitAndCheck(42, 44);
        repeat (5) @(negedge clk);   // Catch late flushed nicks.

        $display("Done: %0d errors", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== oooExec.f ====
+incdir+src
src/oooExecPkg.sv
src/issueReceiver.sv
src/reservationStation.sv
src/execute.sv
src/oooExecTop.sv
tb/oooExecTb.sv

// ==== Bender.yml ====
package:
  name: oooExec

export_include_dirs:
  - src

sources:
  - files:
      - src/oooExecPkg.sv
      - src/issueReceiver.sv
      - src/reservationStation.sv
      - src/execute.sv
      - src/oooExecTop.sv
  - target: test
    files:
      - tb/oooExecTb.sv
